// ==== compile.f ====
+incdir+design
design/chsum_stream_pkg.sv
design/chsum_result_pkg.sv
design/sync_fifo.sv
design/frame_control_fsm.sv
design/byte_position_counter.sv
design/ones_complement_accumulator.sv
design/checksum_calculator.sv
test/checksum_scoreboard.sv
test/tb_checksum_calculator.sv

// ==== design/byte_position_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Byte position counter.
// Frame byte position of the word being taken.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "chsum_config.svh"

module byte_position_counter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       word_take,
    input  logic                       header_load,
    output logic [`CHSUM_OFFSET_W-1:0] word_base
);

    localparam int W = `CHSUM_OFFSET_W;
    localparam logic [W-1:0] STEP = W'(`CHSUM_WORD_BYTES);

    logic [W-1:0] pos_q;

    // The first word of a frame always starts at byte 0.
    assign word_base = header_load ? '0 : pos_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pos_q <= '0;
        end else if (word_take) begin
            pos_q <= word_base + STEP;
        end
    end

    // Frames longer than the offset range are not supported.
    assert property (@(posedge clk) disable iff (reset)
        word_take |=> (pos_q > $past(word_base)))
        else $error("byte_position_counter: position wrapped inside a frame");

endmodule

// ==== design/checksum_calculator.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Packet checksum calculator.
// Takes framed words with per-packet ranges, returns one checksum per packet.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "chsum_config.svh"

module checksum_calculator (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [`CHSUM_WORD_BYTES*8-1:0] rx_data,
    input  logic                           rx_sof,
    input  logic                           rx_eof,
    input  logic [`CHSUM_POS_W-1:0]        rx_eof_pos,
    input  logic [`CHSUM_OFFSET_W-1:0]     rx_offset,
    input  logic [`CHSUM_LENGTH_W-1:0]     rx_length,
    input  logic                           rx_chsum_en,
    input  logic [`CHSUM_META_W-1:0]       rx_meta,
    input  logic                           rx_src_rdy,
    output logic                           rx_dst_rdy,
    output logic [15:0]                    tx_checksum,
    output logic                           tx_bypass,
    output logic [`CHSUM_META_W-1:0]       tx_meta,
    output logic                           tx_src_rdy,
    input  logic                           tx_dst_rdy
);

    chsum_stream_pkg::stream_word_t  in_word;
    chsum_stream_pkg::stream_word_t  cur_word;
    chsum_result_pkg::chsum_result_t acc_result;
    chsum_result_pkg::chsum_result_t out_result;
    logic                            in_full;
    logic                            in_empty;
    logic                            out_empty;
    logic                            out_room;
    logic                            pop;
    logic                            word_take;
    logic                            header_load;
    logic                            frame_end;
    logic                            result_push;
    logic [`CHSUM_OFFSET_W-1:0]      word_base;

    assign in_word.data            = rx_data;
    assign in_word.sof             = rx_sof;
    assign in_word.eof             = rx_eof;
    assign in_word.eof_pos         = rx_eof_pos;
    assign in_word.header.offset   = rx_offset;
    assign in_word.header.length   = rx_length;
    assign in_word.header.chsum_en = rx_chsum_en;
    assign in_word.header.meta     = rx_meta;

    assign rx_dst_rdy  = ~in_full;
    assign tx_src_rdy  = ~out_empty;
    assign tx_checksum = out_result.checksum;
    assign tx_bypass   = out_result.bypass;
    assign tx_meta     = out_result.meta;

    sync_fifo #(
        .payload_t (chsum_stream_pkg::stream_word_t),
        .DEPTH     (`CHSUM_IN_DEPTH)
    ) in_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (rx_src_rdy && rx_dst_rdy),
        .push_data (in_word),
        .pop       (pop),
        .pop_data  (cur_word),
        .full      (in_full),
        .empty     (in_empty),
        .room_two  ()
    );

    frame_control_fsm fsm_i (
        .clk         (clk),
        .reset       (reset),
        .word_avail  (~in_empty),
        .out_room    (out_room),
        .word        (cur_word),
        .pop         (pop),
        .word_take   (word_take),
        .header_load (header_load),
        .frame_end   (frame_end)
    );

    byte_position_counter pos_i (
        .clk         (clk),
        .reset       (reset),
        .word_take   (word_take),
        .header_load (header_load),
        .word_base   (word_base)
    );

    ones_complement_accumulator acc_i (
        .clk         (clk),
        .reset       (reset),
        .word_take   (word_take),
        .header_load (header_load),
        .frame_end   (frame_end),
        .word        (cur_word),
        .word_base   (word_base),
        .result_push (result_push),
        .result      (acc_result)
    );

    sync_fifo #(
        .payload_t (chsum_result_pkg::chsum_result_t),
        .DEPTH     (`CHSUM_OUT_DEPTH)
    ) out_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (result_push),
        .push_data (acc_result),
        .pop       (tx_src_rdy && tx_dst_rdy),
        .pop_data  (out_result),
        .full      (),
        .empty     (out_empty),
        .room_two  (out_room)
    );

endmodule

// ==== design/chsum_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// Checksum calculator configuration.
// Word size, field widths and FIFO depths.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef CHSUM_CONFIG_SVH
`define CHSUM_CONFIG_SVH

// Bytes per stream word and width of the end position.
`define CHSUM_WORD_BYTES 8
`define CHSUM_POS_W      3

// Per-packet header fields.
`define CHSUM_OFFSET_W   11
`define CHSUM_LENGTH_W   11
`define CHSUM_META_W     8

// FIFO depths.
`define CHSUM_IN_DEPTH   4
`define CHSUM_OUT_DEPTH  4

`endif

// ==== design/chsum_result_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Result record types.
// One record per packet on the output side.
// ~~~~~~~~~~~~~~~~~~~~

`include "chsum_config.svh"

package chsum_result_pkg;

    // Checksum is zero when bypass is set.
    typedef struct packed {
        logic [15:0]              checksum;
        logic                     bypass;
        logic [`CHSUM_META_W-1:0] meta;
    } chsum_result_t;

endpackage

// ==== design/chsum_stream_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Input stream types.
// Frame word and per-packet header.
// ~~~~~~~~~~~~~~~~~~~~

`include "chsum_config.svh"

package chsum_stream_pkg;

    // Metadata valid on the start-of-frame word.
    typedef struct packed {
        logic [`CHSUM_OFFSET_W-1:0] offset;
        logic [`CHSUM_LENGTH_W-1:0] length;
        logic                       chsum_en;
        logic [`CHSUM_META_W-1:0]   meta;
    } stream_header_t;

    // Byte 0 of the word sits in data[7:0].
    typedef struct packed {
        logic [`CHSUM_WORD_BYTES*8-1:0] data;
        logic                           sof;
        logic                           eof;
        logic [`CHSUM_POS_W-1:0]        eof_pos;
        stream_header_t                 header;
    } stream_word_t;

endpackage

// ==== design/frame_control_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Frame control FSM.
// Pops input words and strobes header capture and frame finish.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module frame_control_fsm (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           word_avail,
    input  logic                           out_room,
    input  chsum_stream_pkg::stream_word_t word,
    output logic                           pop,
    output logic                           word_take,
    output logic                           header_load,
    output logic                           frame_end
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FRAME,
        ST_DROP
    } state_t;

    state_t state_q;
    state_t state_d;

    // Only pop when both possible in-flight results still fit.
    assign pop = word_avail && out_room;

    always_comb begin
        state_d     = state_q;
        word_take   = 1'b0;
        header_load = 1'b0;
        frame_end   = 1'b0;
        if (pop) begin
            case (state_q)
                ST_IDLE: begin
                    if (word.sof) begin
                        word_take   = 1'b1;
                        header_load = 1'b1;
                        frame_end   = word.eof;
                        if (!word.eof) begin
                            state_d = ST_FRAME;
                        end
                    end else if (!word.eof) begin
                        state_d = ST_DROP;
                    end
                end
                ST_FRAME: begin
                    word_take = 1'b1;
                    frame_end = word.eof;
                    if (word.eof) begin
                        state_d = ST_IDLE;
                    end
                end
                ST_DROP: begin
                    // discard until the stray frame closes
                    if (word.eof) begin
                        state_d = ST_IDLE;
                    end
                end
                default: state_d = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // A new frame must not start before the current one has ended.
    assert property (@(posedge clk) disable iff (reset)
        (pop && state_q == ST_FRAME) |-> !word.sof)
        else $error("frame_control_fsm: start of frame inside a frame");

endmodule

// ==== design/ones_complement_accumulator.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Ones' complement accumulator.
// Sums masked byte pairs per word, then folds and inverts per packet.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "chsum_config.svh"

module ones_complement_accumulator (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            word_take,
    input  logic                            header_load,
    input  logic                            frame_end,
    input  chsum_stream_pkg::stream_word_t  word,
    input  logic [`CHSUM_OFFSET_W-1:0]      word_base,
    output logic                            result_push,
    output chsum_result_pkg::chsum_result_t result
);

    localparam int BYTES = `CHSUM_WORD_BYTES;
    localparam int POS_W = `CHSUM_OFFSET_W + 1;

    chsum_stream_pkg::stream_header_t hdr_q;
    chsum_stream_pkg::stream_header_t cur_hdr;
    logic [POS_W-1:0]                 range_lo;
    logic [POS_W-1:0]                 range_hi;
    logic [31:0]                      word_sum;
    logic [31:0]                      sum_q;
    logic                             last_q;
    logic                             fin_en_q;
    logic [`CHSUM_META_W-1:0]         fin_meta_q;
    logic [16:0]                      fold1;
    logic [15:0]                      fold2;

    // Header of the sof word is used directly, later words use the latch.
    assign cur_hdr  = header_load ? word.header : hdr_q;
    assign range_lo = {1'b0, cur_hdr.offset};
    assign range_hi = {1'b0, cur_hdr.offset} + {1'b0, cur_hdr.length};

    always_comb begin : mask_sum
        logic [POS_W-1:0] pos;
        logic [15:0]      lane_val;
        word_sum = '0;
        for (int i = 0; i < BYTES; i++) begin
            pos      = {1'b0, word_base} + POS_W'(i);
            lane_val = '0;
            if (pos >= range_lo && pos < range_hi &&
                (!word.eof || i <= int'(word.eof_pos))) begin
                // Even distance from the offset is the high byte of a pair.
                if (pos[0] == cur_hdr.offset[0]) begin
                    lane_val = {word.data[8*i +: 8], 8'h00};
                end else begin
                    lane_val = {8'h00, word.data[8*i +: 8]};
                end
            end
            word_sum = word_sum + 32'(lane_val);
        end
    end

    always_ff @(posedge clk) begin
        if (header_load) begin
            hdr_q <= word.header;
        end
        if (word_take) begin
            sum_q <= (header_load ? '0 : sum_q) + word_sum;
            if (frame_end) begin
                fin_en_q   <= cur_hdr.chsum_en;
                fin_meta_q <= cur_hdr.meta;
            end
        end
    end

    // Two folds are enough for a 32-bit sum.
    assign fold1 = {1'b0, sum_q[15:0]} + {1'b0, sum_q[31:16]};
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    always_ff @(posedge clk) begin
        if (last_q) begin
            result.checksum <= fin_en_q ? ~fold2 : '0;
            result.bypass   <= ~fin_en_q;
            result.meta     <= fin_meta_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_q      <= 1'b0;
            result_push <= 1'b0;
        end else begin
            last_q      <= word_take && frame_end;
            result_push <= last_q;
        end
    end

    // The checked range has to end inside the packet.
    assert property (@(posedge clk) disable iff (reset)
        (word_take && frame_end) |->
            (range_hi <= {1'b0, word_base} + POS_W'(word.eof_pos) + POS_W'(1)))
        else $error("ones_complement_accumulator: range runs past the packet end");

endmodule

// ==== design/sync_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO.
// Circular buffer with a typed payload and first-word fall-through read.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty,
    output logic     room_two
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;

    assign pop_data = mem[rd_ptr_q];
    assign full     = (count_q == CNT_W'(DEPTH));
    assign empty    = (count_q == '0);
    // A push in progress counts as taken already.
    assign room_two = ({1'b0, count_q} + (CNT_W + 1)'(push)) <= (CNT_W + 1)'(DEPTH - 2);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("sync_fifo: push while full");
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

// ==== test/checksum_scoreboard.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Checksum scoreboard.
// Rebuilds each packet from the rx side and checks every tx result.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "chsum_config.svh"

module checksum_scoreboard (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [`CHSUM_WORD_BYTES*8-1:0] rx_data,
    input  logic                           rx_sof,
    input  logic                           rx_eof,
    input  logic [`CHSUM_POS_W-1:0]        rx_eof_pos,
    input  logic [`CHSUM_OFFSET_W-1:0]     rx_offset,
    input  logic [`CHSUM_LENGTH_W-1:0]     rx_length,
    input  logic                           rx_chsum_en,
    input  logic [`CHSUM_META_W-1:0]       rx_meta,
    input  logic                           rx_src_rdy,
    input  logic                           rx_dst_rdy,
    input  logic [15:0]                    tx_checksum,
    input  logic                           tx_bypass,
    input  logic [`CHSUM_META_W-1:0]       tx_meta,
    input  logic                           tx_src_rdy,
    input  logic                           tx_dst_rdy,
    output int                             result_count,
    output int                             error_count
);

    chsum_result_pkg::chsum_result_t exp_q[$];
    logic [7:0]                      pkt_bytes[$];
    int                              hdr_offset;
    int                              hdr_length;
    logic                            hdr_en;
    logic [`CHSUM_META_W-1:0]        hdr_meta;

    // Big-endian pairs counted from the offset, odd tail padded with zero.
    function automatic chsum_result_pkg::chsum_result_t model_checksum(
        input logic [7:0]               bytes[$],
        input int                       offset,
        input int                       length,
        input logic                     en,
        input logic [`CHSUM_META_W-1:0] meta
    );
        chsum_result_pkg::chsum_result_t r;
        logic [31:0]                     sum;
        logic [7:0]                      lo;
        sum = '0;
        for (int k = 0; k < length; k += 2) begin
            lo  = (k + 1 < length) ? bytes[offset + k + 1] : 8'h00;
            sum = sum + {16'h0000, bytes[offset + k], lo};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        r.checksum = en ? ~sum[15:0] : 16'h0000;
        r.bypass   = !en;
        r.meta     = meta;
        return r;
    endfunction

    always @(posedge clk) begin : watch
        chsum_result_pkg::chsum_result_t exp;
        if (reset) begin
            exp_q.delete();
            pkt_bytes.delete();
            result_count <= 0;
            error_count  <= 0;
        end else begin
            if (rx_src_rdy && rx_dst_rdy) begin
                if (rx_sof) begin
                    pkt_bytes.delete();
                    hdr_offset = int'(rx_offset);
                    hdr_length = int'(rx_length);
                    hdr_en     = rx_chsum_en;
                    hdr_meta   = rx_meta;
                end
                for (int b = 0; b < `CHSUM_WORD_BYTES; b++) begin
                    if (!rx_eof || b <= int'(rx_eof_pos)) begin
                        pkt_bytes.push_back(rx_data[8*b +: 8]);
                    end
                end
                if (rx_eof) begin
                    exp_q.push_back(model_checksum(pkt_bytes, hdr_offset, hdr_length,
                                                   hdr_en, hdr_meta));
                end
            end
            if (tx_src_rdy && tx_dst_rdy) begin
                result_count <= result_count + 1;
                if (exp_q.size() == 0) begin
                    $display("ERROR %0t: result %h arrived with no packet pending",
                             $time, tx_checksum);
                    error_count <= error_count + 1;
                end else begin
                    exp = exp_q.pop_front();
                    if (tx_checksum !== exp.checksum || tx_bypass !== exp.bypass ||
                        tx_meta !== exp.meta) begin
                        $display("ERROR %0t: result %0d got %h/%b/%h, expected %h/%b/%h",
                                 $time, result_count, tx_checksum, tx_bypass, tx_meta,
                                 exp.checksum, exp.bypass, exp.meta);
                        error_count <= error_count + 1;
                    end
                end
            end
        end
    end

endmodule

// ==== test/tb_checksum_calculator.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Checksum calculator testbench.
// Random packets with rx gaps and tx back-pressure.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "chsum_config.svh"

module tb_checksum_calculator;

    localparam int WAIT_LIMIT = 1000;
    localparam int TX_FREE    = 0;
    localparam int TX_STALL   = 1;
    localparam int TX_RANDOM  = 2;
    localparam int TX_BURST   = 3;

    logic                           clk;
    logic                           reset;
    logic [`CHSUM_WORD_BYTES*8-1:0] rx_data;
    logic                           rx_sof;
    logic                           rx_eof;
    logic [`CHSUM_POS_W-1:0]        rx_eof_pos;
    logic [`CHSUM_OFFSET_W-1:0]     rx_offset;
    logic [`CHSUM_LENGTH_W-1:0]     rx_length;
    logic                           rx_chsum_en;
    logic [`CHSUM_META_W-1:0]       rx_meta;
    logic                           rx_src_rdy;
    logic                           rx_dst_rdy;
    logic [15:0]                    tx_checksum;
    logic                           tx_bypass;
    logic [`CHSUM_META_W-1:0]       tx_meta;
    logic                           tx_src_rdy;
    logic                           tx_dst_rdy;

    int          tx_mode;
    logic [31:0] stim_state;
    logic [31:0] tx_state;
    int          burst_left;
    logic        burst_level;
    int          packets_sent;
    int          tb_fails;
    bit          timeout_hit;
    bit          stall_seen;
    int          result_count;
    int          error_count;

    checksum_calculator dut_i (
        .clk(clk), .reset(reset),
        .rx_data(rx_data), .rx_sof(rx_sof), .rx_eof(rx_eof), .rx_eof_pos(rx_eof_pos),
        .rx_offset(rx_offset), .rx_length(rx_length), .rx_chsum_en(rx_chsum_en),
        .rx_meta(rx_meta), .rx_src_rdy(rx_src_rdy), .rx_dst_rdy(rx_dst_rdy),
        .tx_checksum(tx_checksum), .tx_bypass(tx_bypass), .tx_meta(tx_meta),
        .tx_src_rdy(tx_src_rdy), .tx_dst_rdy(tx_dst_rdy)
    );

    checksum_scoreboard checker_i (
        .clk(clk), .reset(reset),
        .rx_data(rx_data), .rx_sof(rx_sof), .rx_eof(rx_eof), .rx_eof_pos(rx_eof_pos),
        .rx_offset(rx_offset), .rx_length(rx_length), .rx_chsum_en(rx_chsum_en),
        .rx_meta(rx_meta), .rx_src_rdy(rx_src_rdy), .rx_dst_rdy(rx_dst_rdy),
        .tx_checksum(tx_checksum), .tx_bypass(tx_bypass), .tx_meta(tx_meta),
        .tx_src_rdy(tx_src_rdy), .tx_dst_rdy(tx_dst_rdy),
        .result_count(result_count), .error_count(error_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function int unsigned stim_rand(input int unsigned n);
        stim_state = lcg_next(stim_state);
        return {16'h0000, stim_state[31:16]} % n;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Output ready pattern, with its own random stream.
    always @(posedge clk) begin
        tx_state = lcg_next(tx_state);
        case (tx_mode)
            TX_STALL:  tx_dst_rdy <= 1'b0;
            TX_RANDOM: tx_dst_rdy <= tx_state[20];
            TX_BURST: begin
                if (burst_left == 0) begin
                    burst_left  = 1 + int'(tx_state[19:16]);
                    burst_level = tx_state[23];
                end else begin
                    burst_left = burst_left - 1;
                end
                tx_dst_rdy <= burst_level;
            end
            default:   tx_dst_rdy <= 1'b1;
        endcase
    end

    task send_word(input logic [`CHSUM_WORD_BYTES*8-1:0] data, input bit sof, input bit eof,
                   input logic [`CHSUM_POS_W-1:0] eof_pos, input int offset, input int length,
                   input bit en, input logic [`CHSUM_META_W-1:0] meta, input int gap);
        int waited;
        waited = 0;
        if (!timeout_hit) begin
            repeat (gap) begin
                rx_src_rdy <= 1'b0;
                @(posedge clk);
            end
            rx_data     <= data;
            rx_sof      <= sof;
            rx_eof      <= eof;
            rx_eof_pos  <= eof_pos;
            rx_offset   <= `CHSUM_OFFSET_W'(offset);
            rx_length   <= `CHSUM_LENGTH_W'(length);
            rx_chsum_en <= en;
            rx_meta     <= meta;
            rx_src_rdy  <= 1'b1;
            @(posedge clk);
            while (!rx_dst_rdy && !timeout_hit) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    $display("timeout: input side not ready for %0d cycles", WAIT_LIMIT);
                    timeout_hit = 1'b1;
                end else begin
                    @(posedge clk);
                end
            end
        end
    endtask

    task send_packet(input int size, input int offset, input int length, input bit en,
                     input int max_gap);
        logic [`CHSUM_WORD_BYTES*8-1:0] data;
        logic [`CHSUM_META_W-1:0]       meta;
        int                             nwords;
        int                             gap;
        meta   = `CHSUM_META_W'(stim_rand(256));
        nwords = (size + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            // Bytes past eof_pos are random too, so masking is exercised.
            for (int b = 0; b < `CHSUM_WORD_BYTES; b++) begin
                data[8*b +: 8] = 8'(stim_rand(256));
            end
            gap = (max_gap > 0) ? int'(stim_rand(max_gap + 1)) : 0;
            send_word(data, w == 0, w == nwords - 1, `CHSUM_POS_W'((size - 1) % 8),
                      offset, length, en, meta, gap);
        end
        packets_sent++;
    endtask

    task send_random_packet(input bit en, input int max_gap);
        int size;
        int offset;
        int length;
        size   = 1 + int'(stim_rand(64));
        offset = int'(stim_rand(size + 1));
        length = int'(stim_rand(size - offset + 1));
        send_packet(size, offset, length, en, max_gap);
    endtask

    task finish_test(input string name);
        int waited;
        waited = 0;
        rx_src_rdy <= 1'b0;
        while (result_count != packets_sent && !timeout_hit) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: %s has %0d of %0d results", name, result_count, packets_sent);
                timeout_hit = 1'b1;
            end
        end
        $display("test %s: done, %0d packets, %0d results, %0d mismatches",
                 name, packets_sent, result_count, error_count);
    endtask

    task check_reset_state();
        if (tx_src_rdy !== 1'b0) begin
            $display("ERROR %0t: tx_src_rdy is %b after reset, expected 0", $time, tx_src_rdy);
            tb_fails++;
        end
        if (rx_dst_rdy !== 1'b1) begin
            $display("ERROR %0t: rx_dst_rdy is %b after reset, expected 1", $time, rx_dst_rdy);
            tb_fails++;
        end
        $display("test reset_state: done, %0d failures", tb_fails);
    endtask

    task run_single_word();
        int size;
        int offset;
        int length;
        repeat (20) begin
            size   = 2 + 2 * int'(stim_rand(4));
            offset = 2 * int'(stim_rand(size / 2 + 1));
            length = 2 * int'(stim_rand((size - offset) / 2 + 1));
            send_packet(size, offset, length, 1'b1, 2);
        end
        finish_test("single_word");
    endtask

    task run_odd_ranges();
        int size;
        int offset;
        int length;
        tx_mode <= TX_RANDOM;
        repeat (20) begin
            size   = 17 + int'(stim_rand(48));
            offset = 2 * int'(stim_rand(8)) + 1;
            length = 2 * int'(stim_rand((size - offset + 1) / 2)) + 1;
            send_packet(size, offset, length, 1'b1, 2);
        end
        finish_test("odd_ranges");
    endtask

    task run_backpressure();
        stall_seen = 1'b0;
        tx_mode <= TX_STALL;
        fork
            begin
                repeat (300) begin
                    @(posedge clk);
                    if (!rx_dst_rdy) begin
                        stall_seen = 1'b1;
                    end
                end
                tx_mode <= TX_FREE;
            end
            repeat (16) send_random_packet(1'b1, 0);
        join
        if (!stall_seen) begin
            $display("rx_dst_rdy never fell while the output was stalled");
            tb_fails++;
        end
        finish_test("backpressure");
    endtask

    initial begin
        stim_state   = 32'd20782;
        tx_state     = 32'd20782 ^ 32'hA5A5_A5A5;
        tx_mode      = TX_FREE;
        burst_left   = 0;
        burst_level  = 1'b1;
        packets_sent = 0;
        tb_fails     = 0;
        timeout_hit  = 1'b0;
        reset        = 1'b1;
        rx_data      = '0;
        rx_sof       = 1'b0;
        rx_eof       = 1'b0;
        rx_eof_pos   = '0;
        rx_offset    = '0;
        rx_length    = '0;
        rx_chsum_en  = 1'b0;
        rx_meta      = '0;
        rx_src_rdy   = 1'b0;
        tx_dst_rdy   = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_reset_state();
        run_single_word();
        run_odd_ranges();
        tx_mode <= TX_FREE;
        repeat (20) send_random_packet(1'b0, 2);
        finish_test("bypass");
        run_backpressure();
        tx_mode <= TX_BURST;
        repeat (300) send_random_packet(stim_rand(2) == 1, 3);
        finish_test("random_mix");
        $display("summary: %0d packets, %0d results, %0d mismatches, %0d other failures",
                 packets_sent, result_count, error_count, tb_fails);
        if (timeout_hit || error_count != 0 || tb_fails != 0 || result_count != packets_sent) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule
